// ==== verilog/midiPkg.sv ====
package midiPkg;

	// Serial timing at 50 MHz and 31250 baud
	localparam int bitPeriod = 1600;
	// Sample point inside a bit
	localparam int halfBitPeriod = 800;

	// Controller number for all notes off
	localparam logic [6:0] ccAllNotesOff = 7'd123;

	// Plain vector types
	typedef logic [7:0] midiByteT;
	typedef logic [6:0] noteNumT;
	typedef logic [6:0] velocityT;
	typedef logic [3:0] channelT;
	// 0 to 128 held notes
	typedef logic [7:0] noteCountT;
	// Wide enough for one bit period
	typedef logic [$clog2(bitPeriod)-1:0] bitTimerT;

	// One note event, 15 bits
	typedef struct packed {
		logic     noteOn;
		noteNumT  note;
		velocityT velocity;
	} noteEventT;

	// Channel filter setting
	typedef struct packed {
		channelT channel;
		logic    omni;
	} midiCfgT;

	// Receiver FSM
	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxStateT;

endpackage

// ==== verilog/resetGen.sv ====
`timescale 1ns/1ps

module resetGen (
	input  logic iMCLK,
	input  logic qlocked,
	output logic rnMRST
);

	// First stage of the release synchronizer
	logic rstMeta;

	// Lock loss clears both stages at once
	// Release ripples through on two clock edges
	always_ff @(posedge iMCLK or negedge qlocked)
	begin
		if (!qlocked)
		begin
			rstMeta <= 1'b0;
			rnMRST  <= 1'b0;
		end
		else
		begin
			rstMeta <= 1'b1;
			rnMRST  <= rstMeta;
		end
	end

endmodule

// ==== verilog/midiRx.sv ====
`timescale 1ns/1ps

module midiRx
	import midiPkg::*;
(
	input  logic     iMCLK,
	input  logic     qlocked,
	input  logic     rxLine,
	output midiByteT rxByte,
	output logic     rxValid,
	output logic     rxBusy,
	output logic     framingErr,
	output logic     thruLine
);

	// Synchronizer and edge detect
	logic     lineMeta;
	logic     lineSync;
	logic     linePrev;
	// Bit timing
	rxStateT  state;
	bitTimerT bitTimer;
	logic [2:0] bitIndex;
	midiByteT shiftReg;
	logic     bitDone;
	logic     halfDone;

	// ----------------------------------------------------------------------
	// Line synchronizer
	// ----------------------------------------------------------------------
	// Idle line is high, so reset to 1
	always_ff @(posedge iMCLK or negedge qlocked)
	begin
		if (!qlocked)
		begin
			lineMeta <= 1'b1;
			lineSync <= 1'b1;
			linePrev <= 1'b1;
		end
		else
		begin
			lineMeta <= rxLine;
			lineSync <= lineMeta;
			linePrev <= lineSync;
		end
	end

	// Thru copy of the synchronized line
	assign thruLine = lineSync;

	assign bitDone  = (bitTimer == bitTimerT'(bitPeriod - 1));
	assign halfDone = (bitTimer == bitTimerT'(halfBitPeriod - 1));

	// ----------------------------------------------------------------------
	// Receive FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge iMCLK or negedge qlocked)
	begin
		if (!qlocked)
		begin
			state      <= rxIdle;
			bitTimer   <= '0;
			bitIndex   <= '0;
			rxValid    <= 1'b0;
			framingErr <= 1'b0;
		end
		else
		begin
			rxValid <= 1'b0;
			case (state)
				rxIdle:
				begin
					bitTimer <= '0;
					bitIndex <= '0;
					// Falling edge marks a start bit
					if (linePrev && !lineSync)
						state <= rxStart;
				end
				rxStart:
				begin
					if (halfDone)
					begin
						bitTimer <= '0;
						// Glitch check at mid start bit
						state <= lineSync ? rxIdle : rxData;
					end
					else
						bitTimer <= bitTimer + 1'b1;
				end
				rxData:
				begin
					if (bitDone)
					begin
						bitTimer <= '0;
						bitIndex <= bitIndex + 1'b1;
						if (bitIndex == 3'd7)
							state <= rxStop;
					end
					else
						bitTimer <= bitTimer + 1'b1;
				end
				rxStop:
				begin
					if (bitDone)
					begin
						state <= rxIdle;
						// Low stop bit drops the byte, error is sticky
						if (lineSync)
							rxValid <= 1'b1;
						else
							framingErr <= 1'b1;
					end
					else
						bitTimer <= bitTimer + 1'b1;
				end
				default:
					state <= rxIdle;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge iMCLK)
	begin
		if (state == rxData && bitDone)
			shiftReg <= {lineSync, shiftReg[7:1]};
	end

	assign rxByte = shiftReg;
	assign rxBusy = (state != rxIdle);

endmodule

// ==== verilog/midiConfig.sv ====
`timescale 1ns/1ps

module midiConfig
	import midiPkg::*;
(
	input  logic    iMCLK,
	input  logic    qlocked,
	input  midiCfgT cfgIn,
	input  logic    loadStrobe,
	output midiCfgT cfg,
	output logic    cfgLoaded
);

	// Strobe synchronizer plus previous value
	logic strobeMeta;
	logic strobeSync;
	logic strobePrev;
	logic strobeRise;

	assign strobeRise = strobeSync && !strobePrev;

	always_ff @(posedge iMCLK or negedge qlocked)
	begin
		if (!qlocked)
		begin
			strobeMeta <= 1'b0;
			strobeSync <= 1'b0;
			strobePrev <= 1'b0;
			// Channel 0, omni off
			cfg        <= '0;
			cfgLoaded  <= 1'b0;
		end
		else
		begin
			strobeMeta <= loadStrobe;
			strobeSync <= strobeMeta;
			strobePrev <= strobeSync;
			// Pins are stable long before the strobe edge
			if (strobeRise)
				cfg <= cfgIn;
			// Table flush for notes of the old filter
			cfgLoaded <= strobeRise;
		end
	end

endmodule

// ==== verilog/midiParser.sv ====
`timescale 1ns/1ps

module midiParser
	import midiPkg::*;
(
	input  logic       iMCLK,
	input  logic       qlocked,
	input  midiByteT   rxByte,
	input  logic       rxValid,
	input  midiCfgT    cfg,
	output noteEventT  noteEvt,
	output logic       evtValid,
	output logic       allOff,
	output noteEventT  lastEvt,
	output logic [8:0] evtCount
);

	// Running status
	midiByteT  statusByte;
	logic      statusValid;
	logic      haveFirst;
	noteNumT   firstData;
	// Byte classes
	logic      isData;
	logic      isRealtime;
	logic      isSystem;
	logic      isChanStatus;
	// Message decode
	logic      oneDataByte;
	logic      chanMatch;
	logic      msgDone;
	logic      acceptNote;
	logic      acceptOff;
	noteEventT newEvt;

	// ----------------------------------------------------------------------
	// Decode
	// ----------------------------------------------------------------------
	always_comb
	begin
		isData       = !rxByte[7];
		isRealtime   = (rxByte >= 8'hF8);
		isSystem     = (rxByte[7:4] == 4'hF) && !isRealtime;
		isChanStatus = rxByte[7] && (rxByte[7:4] != 4'hF);
		// Program change and channel pressure carry one data byte
		oneDataByte  = (statusByte[7:4] == 4'hC) || (statusByte[7:4] == 4'hD);
		chanMatch    = cfg.omni || (channelT'(statusByte[3:0]) == cfg.channel);
		// Second data byte of a two byte message
		msgDone      = rxValid && isData && statusValid && haveFirst && !oneDataByte;
		acceptNote   = msgDone && chanMatch &&
			((statusByte[7:4] == 4'h9) || (statusByte[7:4] == 4'h8));
		acceptOff    = msgDone && chanMatch && (statusByte[7:4] == 4'hB) &&
			(firstData == ccAllNotesOff);
		// Velocity 0 note on counts as release
		newEvt.noteOn   = (statusByte[7:4] == 4'h9) && (rxByte[6:0] != 7'd0);
		newEvt.note     = firstData;
		newEvt.velocity = velocityT'(rxByte[6:0]);
	end

	// ----------------------------------------------------------------------
	// Status tracking and event output
	// ----------------------------------------------------------------------
	always_ff @(posedge iMCLK or negedge qlocked)
	begin
		if (!qlocked)
		begin
			statusByte  <= '0;
			statusValid <= 1'b0;
			haveFirst   <= 1'b0;
			evtValid    <= 1'b0;
			allOff      <= 1'b0;
			lastEvt     <= '0;
			evtCount    <= '0;
		end
		else
		begin
			evtValid <= acceptNote;
			allOff   <= acceptOff;
			if (acceptNote)
			begin
				lastEvt  <= newEvt;
				evtCount <= evtCount + 1'b1;
			end
			// Realtime bytes fall through untouched
			if (rxValid)
			begin
				if (isChanStatus)
				begin
					statusByte  <= rxByte;
					statusValid <= 1'b1;
					haveFirst   <= 1'b0;
				end
				else if (isSystem)
				begin
					statusValid <= 1'b0;
					haveFirst   <= 1'b0;
				end
				else if (isData && statusValid && !oneDataByte)
					haveFirst <= !haveFirst;
			end
		end
	end

	// First data byte, note or controller number
	always_ff @(posedge iMCLK)
	begin
		if (rxValid && isData && !haveFirst)
			firstData <= noteNumT'(rxByte[6:0]);
	end

	// Event payload is the last accepted event
	assign noteEvt = lastEvt;

endmodule

// ==== verilog/noteTable.sv ====
`timescale 1ns/1ps

module noteTable
	import midiPkg::*;
(
	input  logic      iMCLK,
	input  logic      qlocked,
	input  noteEventT noteEvt,
	input  logic      evtValid,
	input  logic      clear,
	output noteCountT activeCount,
	output logic      anyActive,
	output noteNumT   highestNote
);

	// One bit per note number
	logic [127:0] noteBits;

	always_ff @(posedge iMCLK or negedge qlocked)
	begin
		if (!qlocked)
		begin
			noteBits    <= '0;
			activeCount <= '0;
		end
		else if (clear)
		begin
			noteBits    <= '0;
			activeCount <= '0;
		end
		else if (evtValid)
		begin
			// Count moves only on a real change of the bit
			if (noteEvt.noteOn && !noteBits[noteEvt.note])
			begin
				noteBits[noteEvt.note] <= 1'b1;
				activeCount            <= activeCount + 1'b1;
			end
			else if (!noteEvt.noteOn && noteBits[noteEvt.note])
			begin
				noteBits[noteEvt.note] <= 1'b0;
				activeCount            <= activeCount - 1'b1;
			end
		end
	end

	assign anyActive = (activeCount != '0);

	// Highest set bit wins, 0 when empty
	always_comb
	begin
		highestNote = '0;
		for (int i = 0; i < 128; i++)
			if (noteBits[i])
				highestNote = noteNumT'(i);
	end

endmodule

// ==== verilog/K5Stack10MidiTop.sv ====
`timescale 1ns/1ps

module K5Stack10MidiTop
	import midiPkg::*;
(
	// GPIOL
	input  logic [ 5:0] ioGPIOL_I,
	output logic [ 5:0] ioGPIOL_O,
	output logic [ 5:0] ioGPIOL_OE,
	// GPIOR
	input  logic [17:0] ioGPIOR_I,
	output logic [17:0] ioGPIOR_O,
	output logic [17:0] ioGPIOR_OE,
	// GPIOB
	input  logic [23:0] ioGPIOB_I,
	output logic [23:0] ioGPIOB_O,
	output logic [23:0] ioGPIOB_OE,
	// USB UART, MIDI in and thru
	input  logic        iUSB_RX,
	output logic        oUSB_TX,
	// Clock and PLL lock
	input  logic        iMCLK,
	input  logic        qlocked
);

	logic       rnMRST;
	midiByteT   rxByte;
	logic       rxValid;
	logic       rxBusy;
	logic       framingErr;
	midiCfgT    cfgPins;
	midiCfgT    cfg;
	logic       cfgLoaded;
	noteEventT  noteEvt;
	logic       evtValid;
	logic       allOff;
	noteEventT  lastEvt;
	logic [8:0] evtCount;
	noteCountT  activeCount;
	logic       anyActive;
	noteNumT    highestNote;

	// ----------------------------------------------------------------------
	// Reset and MIDI blocks
	// ----------------------------------------------------------------------
	resetGen u_resetGen (
		.iMCLK   (iMCLK),
		.qlocked (qlocked),
		.rnMRST  (rnMRST)
	);

	midiRx u_midiRx (
		.iMCLK      (iMCLK),
		.qlocked    (rnMRST),
		.rxLine     (iUSB_RX),
		.rxByte     (rxByte),
		.rxValid    (rxValid),
		.rxBusy     (rxBusy),
		.framingErr (framingErr),
		.thruLine   (oUSB_TX)
	);

	midiConfig u_midiConfig (
		.iMCLK      (iMCLK),
		.qlocked    (rnMRST),
		.cfgIn      (cfgPins),
		.loadStrobe (ioGPIOL_I[5]),
		.cfg        (cfg),
		.cfgLoaded  (cfgLoaded)
	);

	midiParser u_midiParser (
		.iMCLK    (iMCLK),
		.qlocked  (rnMRST),
		.rxByte   (rxByte),
		.rxValid  (rxValid),
		.cfg      (cfg),
		.noteEvt  (noteEvt),
		.evtValid (evtValid),
		.allOff   (allOff),
		.lastEvt  (lastEvt),
		.evtCount (evtCount)
	);

	// Table flushes on all notes off or a new filter
	noteTable u_noteTable (
		.iMCLK       (iMCLK),
		.qlocked     (rnMRST),
		.noteEvt     (noteEvt),
		.evtValid    (evtValid),
		.clear       (allOff | cfgLoaded),
		.activeCount (activeCount),
		.anyActive   (anyActive),
		.highestNote (highestNote)
	);

	// ----------------------------------------------------------------------
	// Pin map
	// ----------------------------------------------------------------------
	// GPIOL is input only, filter setting and load strobe
	assign cfgPins.channel = channelT'(ioGPIOL_I[3:0]);
	assign cfgPins.omni    = ioGPIOL_I[4];
	assign ioGPIOL_O       = 6'd0;
	assign ioGPIOL_OE      = 6'd0;
	// Status on GPIOR, inputs unused
	assign ioGPIOR_O  = {rxBusy, framingErr, activeCount, anyActive, highestNote};
	assign ioGPIOR_OE = {18{1'b1}};
	// Last event and event count on GPIOB
	assign ioGPIOB_O  = {lastEvt, evtCount};
	assign ioGPIOB_OE = {24{1'b1}};

endmodule

// ==== verification/midiTop_asserts.sv ====
`timescale 1ns/1ps

module midiTopAsserts (
	input logic iMCLK,
	input logic qlocked,
	input logic rxValid,
	input logic evtValid,
	input logic allOff
);

	// Note event and flush never share a cycle
	evtOffExclusive: assert property (@(posedge iMCLK) disable iff (!qlocked)
		!(evtValid && allOff))
		else $error("evtValid and allOff high in the same cycle");

	// One byte strobe per stop bit
	rxValidSingle: assert property (@(posedge iMCLK) disable iff (!qlocked)
		rxValid |=> !rxValid)
		else $error("rxValid high for two cycles in a row");

	evtAfterByte: assert property (@(posedge iMCLK) disable iff (!qlocked)
		evtValid |-> $past(rxValid))
		else $error("evtValid without rxValid on the cycle before");

	quietInReset: assert property (@(posedge iMCLK)
		!qlocked |-> !(evtValid || rxValid || allOff))
		else $error("strobe active while in reset");

endmodule

bind midiParser midiTopAsserts u_parserAsserts (
	.iMCLK    (iMCLK),
	.qlocked  (qlocked),
	.rxValid  (rxValid),
	.evtValid (evtValid),
	.allOff   (allOff)
);

// Receiver has no events, only the byte strobe is watched
bind midiRx midiTopAsserts u_rxAsserts (
	.iMCLK    (iMCLK),
	.qlocked  (qlocked),
	.rxValid  (rxValid),
	.evtValid (1'b0),
	.allOff   (1'b0)
);

// ==== verification/midiTb.sv ====
`timescale 1ns/1ps

module midiTb
	import midiPkg::*;
();

	// One table row: stimulus and the state expected after it
	typedef struct packed {
		logic [5:0]  gpiol;
		logic [3:0]  nBytes;
		logic [3:0]  badIdx;
		logic [63:0] seq;
		noteEventT   expLast;
		logic [8:0]  expCount;
		noteCountT   expActive;
		logic        expAny;
		noteNumT     expHigh;
		logic        expFrame;
	} stepT;

	// No byte with a low stop bit
	localparam logic [3:0] noBad = 4'hF;

	// DUT pins
	logic        iMCLK;
	logic        qlocked;
	logic        usbRx;
	logic        usbTx;
	logic [5:0]  gpiolIn;
	logic [5:0]  gpiolOut;
	logic [5:0]  gpiolOe;
	logic [17:0] gpiorIn;
	logic [17:0] gpiorOut;
	logic [17:0] gpiorOe;
	logic [23:0] gpiobIn;
	logic [23:0] gpiobOut;
	logic [23:0] gpiobOe;

	// Reference model of parser and held notes
	logic [127:0] heldNotes;
	midiByteT     runStatus;
	logic         statusOk;
	logic         firstSeen;
	noteNumT      firstNote;
	channelT      modelChan;
	logic         modelOmni;
	noteEventT    modelLast;
	logic [8:0]   modelCount;
	logic         modelFrame;

	stepT        steps[$];
	int          totalBytes = 0;
	int          cycleCount = 0;
	int          cycleLimit = 32'h7FFF_FFFF;
	int          mismatchErrors = 0;
	int          timeoutErrors = 0;

	K5Stack10MidiTop u_K5Stack10MidiTop (
		.ioGPIOL_I  (gpiolIn),
		.ioGPIOL_O  (gpiolOut),
		.ioGPIOL_OE (gpiolOe),
		.ioGPIOR_I  (gpiorIn),
		.ioGPIOR_O  (gpiorOut),
		.ioGPIOR_OE (gpiorOe),
		.ioGPIOB_I  (gpiobIn),
		.ioGPIOB_O  (gpiobOut),
		.ioGPIOB_OE (gpiobOe),
		.iUSB_RX    (usbRx),
		.oUSB_TX    (usbTx),
		.iMCLK      (iMCLK),
		.qlocked    (qlocked)
	);

	// 20 ns period
	always #10 iMCLK = ~iMCLK;

	// Watchdog sized from the table length
	always @(posedge iMCLK)
	begin
		cycleCount++;
		if (cycleCount == cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			timeoutErrors++;
			finishRun();
		end
	end

	// ----------------------------------------------------------------------
	// Checks and reporting
	// ----------------------------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			mismatchErrors++;
		end
	endtask

	task finishRun();
		$display("Errors: %0d mismatches, %0d timeouts", mismatchErrors, timeoutErrors);
		if (mismatchErrors == 0 && timeoutErrors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------
	task automatic modelByte(input midiByteT b);
		logic [3:0] kind;
		logic       on;
		kind = runStatus[7:4];
		// System common and exclusive cancel running status
		if (b >= 8'hF0 && b < 8'hF8)
		begin
			statusOk  = 1'b0;
			firstSeen = 1'b0;
		end
		else if (b[7] && b < 8'hF0)
		begin
			runStatus = b;
			statusOk  = 1'b1;
			firstSeen = 1'b0;
		end
		else if (!b[7] && statusOk)
		begin
			// Cn and Dn take one data byte, nothing to do
			if (kind == 4'hC || kind == 4'hD)
				firstSeen = 1'b0;
			else if (!firstSeen)
			begin
				firstNote = b[6:0];
				firstSeen = 1'b1;
			end
			else
			begin
				firstSeen = 1'b0;
				if (modelOmni || runStatus[3:0] == modelChan)
				begin
					if (kind == 4'h9 || kind == 4'h8)
					begin
						// Velocity 0 note on is a release
						on = (kind == 4'h9) && (b[6:0] != 7'd0);
						modelLast = {on, firstNote, b[6:0]};
						modelCount = modelCount + 9'd1;
						heldNotes[firstNote] = on;
					end
					else if (kind == 4'hB && firstNote == 7'd123)
						heldNotes = '0;
				end
			end
		end
		// Realtime bytes leave everything alone
	endtask

	function automatic int modelActive();
		int cnt;
		cnt = 0;
		for (int i = 0; i < 128; i++)
			if (heldNotes[i])
				cnt++;
		return cnt;
	endfunction

	function automatic noteNumT modelHighest();
		noteNumT high;
		logic    found;
		high  = '0;
		found = 1'b0;
		// Scan down from the top note
		for (int i = 127; i >= 0; i--)
		begin
			if (heldNotes[i] && !found)
			begin
				high  = noteNumT'(i);
				found = 1'b1;
			end
		end
		return high;
	endfunction

	// Bytes are given first byte leftmost, right aligned in seq
	task automatic addStep(input logic [5:0] gpiol, input int n, input logic [63:0] seq,
		input logic [3:0] bad);
		stepT s;
		s        = '0;
		s.gpiol  = gpiol;
		s.nBytes = 4'(n);
		s.badIdx = bad;
		s.seq    = seq;
		// Load flushes the held set, counter untouched
		if (gpiol[5])
		begin
			heldNotes = '0;
			modelChan = gpiol[3:0];
			modelOmni = gpiol[4];
		end
		for (int i = 0; i < n; i++)
		begin
			// Dropped byte never reaches the parser
			if (i == int'(bad))
				modelFrame = 1'b1;
			else
				modelByte(seq[8*(n-1-i) +: 8]);
		end
		s.expLast   = modelLast;
		s.expCount  = modelCount;
		s.expActive = noteCountT'(modelActive());
		s.expAny    = (modelActive() != 0);
		s.expHigh   = modelHighest();
		s.expFrame  = modelFrame;
		steps.push_back(s);
		totalBytes += n;
	endtask

	task automatic buildTable();
		noteNumT  note;
		velocityT vel;
		heldNotes  = '0;
		runStatus  = '0;
		statusOk   = 1'b0;
		firstSeen  = 1'b0;
		firstNote  = '0;
		modelChan  = '0;
		modelOmni  = 1'b0;
		modelLast  = '0;
		modelCount = '0;
		modelFrame = 1'b0;
		note       = '0;
		// Note on and off, channel 0
		addStep(6'h00, 3, 64'h903C64, noBad);
		addStep(6'h00, 3, 64'h904050, noBad);
		addStep(6'h00, 3, 64'h803C20, noBad);
		addStep(6'h00, 3, 64'h904000, noBad);
		addStep(6'h00, 3, 64'h90457F, noBad);
		// Running status with clock bytes mixed in
		addStep(6'h00, 7, 64'h9030F84032F841, noBad);
		addStep(6'h00, 3, 64'h30F800, noBad);
		// SysEx start kills running status
		addStep(6'h00, 6, 64'hF03A50F73B51, noBad);
		// Other channels ignored
		addStep(6'h00, 3, 64'h913C64, noBad);
		addStep(6'h00, 3, 64'h9F3C64, noBad);
		// Switch to channel 3
		addStep(6'h23, 0, 64'h0, noBad);
		addStep(6'h00, 3, 64'h903C64, noBad);
		addStep(6'h00, 3, 64'h933C64, noBad);
		// Omni mode
		addStep(6'h33, 3, 64'h954830, noBad);
		addStep(6'h00, 3, 64'h9A4A30, noBad);
		// Controllers, only 123 acts
		addStep(6'h00, 3, 64'hB50764, noBad);
		addStep(6'h00, 3, 64'hB57B00, noBad);
		addStep(6'h20, 6, 64'h903C64904064, noBad);
		addStep(6'h00, 3, 64'hB17B00, noBad);
		addStep(6'h00, 3, 64'hB07B00, noBad);
		// Low stop bit in the middle of a message
		addStep(6'h00, 4, 64'h90415530, 4'd2);
		addStep(6'h00, 3, 64'h904233, noBad);
		// Random filler, on then off of the same note
		for (int k = 0; k < 6; k++)
		begin
			vel = velocityT'($urandom % 128);
			if (k % 2 == 0)
			begin
				note = noteNumT'($urandom % 128);
				addStep(6'h00, 3, 64'({8'h90, 1'b0, note, 1'b0, vel}), noBad);
			end
			else
				addStep(6'h00, 3, 64'({8'h80, 1'b0, note, 1'b0, vel}), noBad);
		end
	endtask

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	// Start bit, eight data bits LSB first, stop bit
	task automatic sendByte(input midiByteT b, input logic stopBit);
		logic [9:0] frame;
		frame = {stopBit, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge iMCLK);
			#2;
			usbRx = frame[i];
			repeat (bitPeriod - 1) @(posedge iMCLK);
		end
		// Idle high after a low stop bit, next start bit needs a falling edge
		if (!stopBit)
		begin
			@(posedge iMCLK);
			#2;
			usbRx = 1'b1;
			repeat (bitPeriod - 1) @(posedge iMCLK);
		end
	endtask

	// Setting first, strobe edge later
	task automatic loadConfig(input logic [4:0] setting);
		@(posedge iMCLK);
		#2;
		gpiolIn = {1'b0, setting};
		repeat (4) @(posedge iMCLK);
		#2;
		gpiolIn[5] = 1'b1;
		repeat (6) @(posedge iMCLK);
		#2;
		gpiolIn[5] = 1'b0;
		repeat (6) @(posedge iMCLK);
	endtask

	task automatic runStep(input stepT s, input int idx);
		int n;
		n = int'(s.nBytes);
		if (s.gpiol[5])
			loadConfig(s.gpiol[4:0]);
		for (int i = 0; i < n; i++)
			sendByte(s.seq[8*(n-1-i) +: 8], i != int'(s.badIdx));
		repeat (2 * bitPeriod) @(posedge iMCLK);
		@(negedge iMCLK);
		checkValue($sformatf("lastEvt[%0d]", idx), 32'(gpiobOut[23:9]), 32'(s.expLast));
		checkValue($sformatf("evtCount[%0d]", idx), 32'(gpiobOut[8:0]), 32'(s.expCount));
		checkValue($sformatf("activeCount[%0d]", idx), 32'(gpiorOut[15:8]), 32'(s.expActive));
		checkValue($sformatf("anyActive[%0d]", idx), 32'(gpiorOut[7]), 32'(s.expAny));
		checkValue($sformatf("highestNote[%0d]", idx), 32'(gpiorOut[6:0]), 32'(s.expHigh));
		checkValue($sformatf("framingErr[%0d]", idx), 32'(gpiorOut[16]), 32'(s.expFrame));
		checkValue($sformatf("rxBusy[%0d]", idx), 32'(gpiorOut[17]), 32'd0);
		checkValue($sformatf("GPIOL_O[%0d]", idx), 32'(gpiolOut), 32'd0);
	endtask

	initial
	begin
		void'($urandom(1303));
		iMCLK    = 1'b0;
		qlocked  = 1'b0;
		usbRx    = 1'b1;
		gpiolIn  = '0;
		gpiorIn  = '0;
		gpiobIn  = '0;
		buildTable();
		cycleLimit = totalBytes * 12 * bitPeriod + 10000;
		// Outputs quiet while the PLL is unlocked
		repeat (8) @(posedge iMCLK);
		@(negedge iMCLK);
		checkValue("GPIOB_O in reset", 32'(gpiobOut), 32'd0);
		checkValue("GPIOR_O in reset", 32'(gpiorOut), 32'd0);
		checkValue("GPIOL_O in reset", 32'(gpiolOut), 32'd0);
		checkValue("GPIOB_OE", 32'(gpiobOe), 32'h00FF_FFFF);
		checkValue("GPIOR_OE", 32'(gpiorOe), 32'h0003_FFFF);
		checkValue("GPIOL_OE", 32'(gpiolOe), 32'd0);
		repeat (8) @(posedge iMCLK);
		#2;
		qlocked = 1'b1;
		repeat (4) @(posedge iMCLK);
		@(negedge iMCLK);
		checkValue("GPIOB_O after reset", 32'(gpiobOut), 32'd0);
		checkValue("GPIOR_O after reset", 32'(gpiorOut), 32'd0);
		checkValue("oUSB_TX idle", 32'(usbTx), 32'd1);
		// Short low pulse, thru follows and start check rejects it
		@(posedge iMCLK);
		#2;
		usbRx = 1'b0;
		repeat (3) @(posedge iMCLK);
		@(negedge iMCLK);
		checkValue("oUSB_TX low", 32'(usbTx), 32'd0);
		@(posedge iMCLK);
		#2;
		usbRx = 1'b1;
		repeat (3) @(posedge iMCLK);
		@(negedge iMCLK);
		checkValue("oUSB_TX high", 32'(usbTx), 32'd1);
		repeat (bitPeriod) @(posedge iMCLK);
		@(negedge iMCLK);
		checkValue("rxBusy after glitch", 32'(gpiorOut[17]), 32'd0);
		checkValue("framingErr after glitch", 32'(gpiorOut[16]), 32'd0);
		for (int k = 0; k < steps.size(); k++)
			runStep(steps[k], k);
		finishRun();
	end

endmodule

// ==== sim.f ====
verilog/midiPkg.sv
verilog/resetGen.sv
verilog/midiRx.sv
verilog/midiConfig.sv
verilog/midiParser.sv
verilog/noteTable.sv
verilog/K5Stack10MidiTop.sv
verification/midiTop_asserts.sv
verification/midiTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MIDI testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f sim.f --top-module midiTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VmidiTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
